// File: logic/tx_slice_pkg.sv
// Shared sizes and encodings for the transmit slice controller, which fixes four slices and four queues
package tx_slice_pkg;

  // ****************************************
  // Sizes
  // ****************************************
  localparam int NUM_SLICE = 4;   // Slices and transmit queues
  localparam int CNT_W     = 20;  // Slice counter and window width
  localparam int TSF_W     = 64;  // TSF width in microseconds
  localparam int QCNT_W    = 8;   // Pending frame count width

  // ****************************************
  // Encodings
  // ****************************************
  typedef enum logic [1:0] {
    CFG_TOTAL = 2'd0,  // Slice period
    CFG_START = 2'd1,  // Window open point
    CFG_END   = 2'd2   // Window close point
  } cfg_op_t;

  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_GRANT = 2'd1,
    ARB_WAIT  = 2'd2
  } arb_state_t;

endpackage

// File: logic/tsf_timer.sv
// CLK_PER_US must be 1 or more, and a TSF load restarts the microsecond phase from zero
`timescale 1ns/10ps

module tsf_timer #(
  parameter int CLK_PER_US = 8
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           tsf_load,
  input  logic [tx_slice_pkg::TSF_W-1:0] tsf_load_value,
  output logic [tx_slice_pkg::TSF_W-1:0] tsf_value,
  output logic                           tsf_pulse_1m
);

  localparam int PRE_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(CLK_PER_US - 1);

  logic [PRE_W-1:0] presc;

  // ****************************************
  // Microsecond prescaler
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rstn) begin
      presc        <= '0;
      tsf_pulse_1m <= 1'b0;
    end else if (tsf_load) begin
      presc        <= '0;        // Realign to the new TSF
      tsf_pulse_1m <= 1'b0;
    end else if (presc == PRE_LAST) begin
      presc        <= '0;
      tsf_pulse_1m <= 1'b1;      // One clock per microsecond
    end else begin
      presc        <= presc + 1'b1;
      tsf_pulse_1m <= 1'b0;
    end
  end

  // ****************************************
  // TSF counter
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tsf_value <= '0;
    end else if (tsf_load) begin
      tsf_value <= tsf_load_value;
    end else if (tsf_pulse_1m) begin
      tsf_value <= tsf_value + 1'b1;  // Advance on the pulse clock
    end
  end

endmodule

// File: logic/time_slice_gen.sv
// Windows are inclusive, start above end keeps a slice closed, and all-zero settings keep it open
`timescale 1ns/10ps

module time_slice_gen (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  logic                                   tsf_pulse_1m,
  input  logic                                   cfg_wr,
  input  tx_slice_pkg::cfg_op_t                  cfg_op,
  input  logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] cfg_idx,
  input  logic [tx_slice_pkg::CNT_W-1:0]         cfg_value,
  output logic [tx_slice_pkg::NUM_SLICE-1:0]     slice_en,
  output logic                                   cycle_start0
);

  localparam int NS = tx_slice_pkg::NUM_SLICE;
  localparam int CW = tx_slice_pkg::CNT_W;

  logic [CW-1:0] cnt_total [NS];  // Period per slice
  logic [CW-1:0] cnt_start [NS];
  logic [CW-1:0] cnt_end   [NS];
  logic [CW-1:0] counter   [NS];

  // ****************************************
  // Configuration registers
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < NS; i++) begin
        cnt_total[i] <= '0;
        cnt_start[i] <= '0;
        cnt_end[i]   <= '0;
      end
    end else if (cfg_wr) begin
      case (cfg_op)
        tx_slice_pkg::CFG_TOTAL: begin
          cnt_total[cfg_idx] <= cfg_value;
        end
        tx_slice_pkg::CFG_START: begin
          cnt_start[cfg_idx] <= cfg_value;
        end
        tx_slice_pkg::CFG_END: begin
          cnt_end[cfg_idx] <= cfg_value;
        end
        default: begin
          cnt_total[cfg_idx] <= cnt_total[cfg_idx];  // Unused opcode ignored
        end
      endcase
    end
  end

  // ****************************************
  // Slice counters
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < NS; i++) begin
        counter[i] <= '0;
      end
    end else if (tsf_pulse_1m) begin
      for (int i = 0; i < NS; i++) begin
        if (counter[i] == cnt_total[i]) begin
          counter[i] <= '0;  // Wrap at period
        end else begin
          counter[i] <= counter[i] + 1'b1;
        end
      end
    end
  end

  // ****************************************
  // Slice enables
  // ****************************************
  // Compared against the counter of the previous clock, so enables lag by one
  always_ff @(posedge clk) begin
    if (!rstn) begin
      slice_en <= '1;  // All slices open out of reset
    end else begin
      for (int i = 0; i < NS; i++) begin
        slice_en[i] <= (counter[i] >= cnt_start[i]) && (counter[i] <= cnt_end[i]);
      end
    end
  end

  assign cycle_start0 = (counter[0] == cnt_total[0]);  // Slice 0 at end of period

endmodule

// File: logic/tx_queue_monitor.sv
// Counts saturate at both ends, so pops on an empty queue and pushes on a full one are lost
`timescale 1ns/10ps

module tx_queue_monitor (
  input  logic                                       clk,
  input  logic                                       rstn,
  input  logic                                       frame_push,
  input  logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] push_queue,
  input  logic                                       frame_pop,
  input  logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] pop_queue,
  output logic [tx_slice_pkg::NUM_SLICE-1:0]         queue_pending
);

  localparam int NS = tx_slice_pkg::NUM_SLICE;
  localparam int QW = tx_slice_pkg::QCNT_W;

  logic [NS-1:0] push_vec;
  logic [NS-1:0] pop_vec;
  logic [QW-1:0] q_count [NS];

  // ****************************************
  // Strobe decode
  // ****************************************
  always_comb begin
    push_vec             = '0;
    pop_vec              = '0;
    push_vec[push_queue] = frame_push;
    pop_vec[pop_queue]   = frame_pop;
  end

  // ****************************************
  // Pending frame counters
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < NS; i++) begin
        q_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NS; i++) begin
        case ({push_vec[i], pop_vec[i]})
          2'b10: begin
            if (q_count[i] != '1) begin
              q_count[i] <= q_count[i] + 1'b1;
            end
          end
          2'b01: begin
            if (q_count[i] != '0) begin
              q_count[i] <= q_count[i] - 1'b1;
            end
          end
          default: begin
            q_count[i] <= q_count[i];  // Idle or push and pop together
          end
        endcase
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NS; i++) begin
      queue_pending[i] = (q_count[i] != '0);
    end
  end

endmodule

// File: logic/tx_slice_arbiter.sv
// One frame in flight at a time, and a slice that closes mid-frame does not abort the grant
`timescale 1ns/10ps

module tx_slice_arbiter (
  input  logic                                       clk,
  input  logic                                       rstn,
  input  logic [tx_slice_pkg::NUM_SLICE-1:0]         slice_en,
  input  logic [tx_slice_pkg::NUM_SLICE-1:0]         queue_pending,
  input  logic                                       tx_done,
  output logic                                       tx_start,
  output logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] tx_queue,
  output logic                                       tx_busy,
  output logic                                       frame_pop,
  output logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] pop_queue
);

  localparam int NS    = tx_slice_pkg::NUM_SLICE;
  localparam int IDX_W = $clog2(NS);

  tx_slice_pkg::arb_state_t state;

  logic [NS-1:0]    eligible;
  logic [IDX_W-1:0] rr_ptr;  // Last granted queue
  logic [IDX_W-1:0] pick;

  assign eligible = slice_en & queue_pending;

  // ****************************************
  // Round-robin search
  // ****************************************
  // Walk downward so the nearest queue after rr_ptr wins
  always_comb begin
    pick = rr_ptr;
    for (int k = NS; k >= 1; k--) begin
      if (eligible[IDX_W'(rr_ptr + k)]) begin
        pick = IDX_W'(rr_ptr + k);
      end
    end
  end

  // ****************************************
  // Grant FSM
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= tx_slice_pkg::ARB_IDLE;
      rr_ptr   <= IDX_W'(NS - 1);  // Queue 0 searched first
      tx_queue <= '0;
    end else begin
      case (state)
        tx_slice_pkg::ARB_IDLE: begin
          if (|eligible) begin
            tx_queue <= pick;
            state    <= tx_slice_pkg::ARB_GRANT;
          end
        end
        tx_slice_pkg::ARB_GRANT: begin
          rr_ptr <= tx_queue;
          state  <= tx_slice_pkg::ARB_WAIT;
        end
        tx_slice_pkg::ARB_WAIT: begin
          if (tx_done) begin
            state <= tx_slice_pkg::ARB_IDLE;  // Count drops on the same edge
          end
        end
        default: begin
          state <= tx_slice_pkg::ARB_IDLE;
        end
      endcase
    end
  end

  assign tx_start  = (state == tx_slice_pkg::ARB_GRANT);
  assign tx_busy   = (state == tx_slice_pkg::ARB_GRANT) || (state == tx_slice_pkg::ARB_WAIT);
  assign frame_pop = (state == tx_slice_pkg::ARB_WAIT) && tx_done;
  assign pop_queue = tx_queue;  // Frame leaves the granted queue

endmodule

// File: logic/tx_slice_top.sv
// Configuration and frame strobes are one clock wide, and the transmitter must answer each grant
`timescale 1ns/10ps

module tx_slice_top #(
  parameter int CLK_PER_US = 8
) (
  input  logic                                       clk,
  input  logic                                       rstn,
  input  logic                                       cfg_wr,
  input  tx_slice_pkg::cfg_op_t                      cfg_op,
  input  logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] cfg_idx,
  input  logic [tx_slice_pkg::CNT_W-1:0]             cfg_value,
  input  logic                                       tsf_load,
  input  logic [tx_slice_pkg::TSF_W-1:0]             tsf_load_value,
  input  logic                                       frame_push,
  input  logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] push_queue,
  input  logic                                       tx_done,
  output logic [tx_slice_pkg::TSF_W-1:0]             tsf_value,
  output logic                                       tsf_pulse_1m,
  output logic [tx_slice_pkg::NUM_SLICE-1:0]         slice_en,
  output logic                                       cycle_start0,
  output logic [tx_slice_pkg::NUM_SLICE-1:0]         queue_pending,
  output logic                                       tx_start,
  output logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] tx_queue,
  output logic                                       tx_busy
);

  logic                                       frame_pop;  // Arbiter to queue monitor
  logic [$clog2(tx_slice_pkg::NUM_SLICE)-1:0] pop_queue;

  tsf_timer #(
    .CLK_PER_US     (CLK_PER_US)
  ) i_tsf_timer (
    .clk            (clk),
    .rstn           (rstn),
    .tsf_load       (tsf_load),
    .tsf_load_value (tsf_load_value),
    .tsf_value      (tsf_value),
    .tsf_pulse_1m   (tsf_pulse_1m)
  );

  time_slice_gen i_time_slice_gen (
    .clk          (clk),
    .rstn         (rstn),
    .tsf_pulse_1m (tsf_pulse_1m),
    .cfg_wr       (cfg_wr),
    .cfg_op       (cfg_op),
    .cfg_idx      (cfg_idx),
    .cfg_value    (cfg_value),
    .slice_en     (slice_en),
    .cycle_start0 (cycle_start0)
  );

  tx_queue_monitor i_tx_queue_monitor (
    .clk           (clk),
    .rstn          (rstn),
    .frame_push    (frame_push),
    .push_queue    (push_queue),
    .frame_pop     (frame_pop),
    .pop_queue     (pop_queue),
    .queue_pending (queue_pending)
  );

  tx_slice_arbiter i_tx_slice_arbiter (
    .clk           (clk),
    .rstn          (rstn),
    .slice_en      (slice_en),
    .queue_pending (queue_pending),
    .tx_done       (tx_done),
    .tx_start      (tx_start),
    .tx_queue      (tx_queue),
    .tx_busy       (tx_busy),
    .frame_pop     (frame_pop),
    .pop_queue     (pop_queue)
  );

endmodule

// File: sim/tb_tx_slice_top.sv
// Run from the project root so sim/tx_slice_vectors.txt is found, and the model assumes CLK_PER_US of 8
`timescale 1ns/10ps

module tb_tx_slice_top;

  localparam int CLK_PER_US    = 8;
  localparam int NS            = tx_slice_pkg::NUM_SLICE;
  localparam int CW            = tx_slice_pkg::CNT_W;
  localparam int TW            = tx_slice_pkg::TSF_W;
  localparam int Q_MAX         = (1 << tx_slice_pkg::QCNT_W) - 1;
  localparam int GRANT_TIMEOUT = 1000;            // Clocks
  localparam int PULSE_TIMEOUT = 4 * CLK_PER_US;

  logic                  clk;
  logic                  rstn;
  logic                  cfg_wr;
  tx_slice_pkg::cfg_op_t cfg_op;
  logic [1:0]            cfg_idx;
  logic [CW-1:0]         cfg_value;
  logic                  tsf_load;
  logic [TW-1:0]         tsf_load_value;
  logic                  frame_push;
  logic [1:0]            push_queue;
  logic                  tx_done;
  logic [TW-1:0]         tsf_value;
  logic                  tsf_pulse_1m;
  logic [NS-1:0]         slice_en;
  logic                  cycle_start0;
  logic [NS-1:0]         queue_pending;
  logic                  tx_start;
  logic [1:0]            tx_queue;
  logic                  tx_busy;

  int            n_mismatch;
  int            n_fail;
  int            cmd_no;
  bit            aborted;
  integer        seed;
  int            grant_q[$];  // Grants seen, oldest first
  int            m_edges;     // Clocks since reset or TSF load
  logic [TW-1:0] m_tsf;
  logic [CW-1:0] m_total [NS];
  logic [CW-1:0] m_start [NS];
  logic [CW-1:0] m_end   [NS];
  logic [CW-1:0] m_cnt   [NS];
  logic [NS-1:0] m_en;
  int            m_qcnt  [NS];
  int            m_state;     // 0 idle, 1 grant, 2 wait
  int            m_rr;
  int            m_txq;

  tx_slice_top #(.CLK_PER_US(CLK_PER_US)) i_tx_slice_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      n_mismatch++;
      $display("mismatch %s at command %0d: expected %0h, actual %0h",
               name, cmd_no, exp_v, act_v);
    end
  endtask

  task automatic report_failure(input string msg);
    n_fail++;
    $display("error at command %0d: %s", cmd_no, msg);
  endtask

  task automatic missing_arguments(input string cmd);
    report_failure($sformatf("vector command %s has missing arguments", cmd));
    aborted = 1'b1;
  endtask

  // ****************************************
  // Reference model, sampled before each edge
  // ****************************************
  always @(posedge clk) begin
    logic [NS-1:0] pend;
    logic [NS-1:0] elig;
    bit            pulse_exp;
    bit            pop;
    bit            found;
    int            idx;
    int            delta;
    if (!rstn) begin
      m_edges = 0;
      m_tsf   = '0;
      for (int i = 0; i < NS; i++) begin
        m_total[i] = '0;
        m_start[i] = '0;
        m_end[i]   = '0;
        m_cnt[i]   = '0;
        m_qcnt[i]  = 0;
      end
      m_en    = '1;
      m_state = 0;
      m_rr    = NS - 1;
      m_txq   = 0;
      grant_q.delete();
    end else begin
      pulse_exp = (m_edges > 0) && (m_edges % CLK_PER_US == 0);
      for (int i = 0; i < NS; i++) begin
        pend[i] = (m_qcnt[i] != 0);
      end
      check_value("tsf_pulse_1m", pulse_exp, tsf_pulse_1m);
      check_value("tsf_value", m_tsf, tsf_value);
      check_value("slice_en", m_en, slice_en);
      check_value("cycle_start0", m_cnt[0] == m_total[0], cycle_start0);
      check_value("queue_pending", pend, queue_pending);
      check_value("tx_start", m_state == 1, tx_start);
      check_value("tx_busy", m_state != 0, tx_busy);
      if (tx_start) begin
        check_value("tx_queue", m_txq, tx_queue);
        grant_q.push_back(tx_queue);
      end
      elig  = m_en & pend;
      pop   = 1'b0;
      found = 1'b0;
      case (m_state)
        0: begin
          for (int k = 1; k <= NS; k++) begin
            idx = (m_rr + k) % NS;  // Search starts after last grant
            if (elig[idx] && !found) begin
              m_txq = idx;
              found = 1'b1;
            end
          end
          if (found) m_state = 1;
        end
        1: begin
          m_rr    = m_txq;
          m_state = 2;
        end
        default: begin
          if (tx_done) begin
            pop     = 1'b1;
            m_state = 0;
          end
        end
      endcase
      for (int i = 0; i < NS; i++) begin
        delta = 0;
        if (frame_push && push_queue == i) delta++;
        if (pop && m_txq == i) delta--;
        if (delta > 0 && m_qcnt[i] < Q_MAX) m_qcnt[i]++;
        else if (delta < 0 && m_qcnt[i] > 0) m_qcnt[i]--;
      end
      for (int i = 0; i < NS; i++) begin
        m_en[i] = (m_start[i] <= m_cnt[i]) && (m_cnt[i] <= m_end[i]);  // Old counter
        if (tsf_pulse_1m) m_cnt[i] = (m_cnt[i] == m_total[i]) ? '0 : m_cnt[i] + 1'b1;
      end
      if (cfg_wr) begin
        case (cfg_op)
          tx_slice_pkg::CFG_TOTAL: m_total[cfg_idx] = cfg_value;
          tx_slice_pkg::CFG_START: m_start[cfg_idx] = cfg_value;
          tx_slice_pkg::CFG_END:   m_end[cfg_idx]   = cfg_value;
          default: m_total[cfg_idx] = m_total[cfg_idx];
        endcase
      end
      if (tsf_load) begin
        m_edges = 0;
        m_tsf   = tsf_load_value;
      end else begin
        if (pulse_exp) m_tsf = m_tsf + 1'b1;
        m_edges++;
      end
    end
  end

  // ****************************************
  // Vector commands
  // ****************************************
  task automatic config_write(input int op, input int idx, input logic [CW-1:0] value);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_op    <= tx_slice_pkg::cfg_op_t'(op);
    cfg_idx   <= 2'(idx);
    cfg_value <= value;
    @(posedge clk);
    cfg_wr    <= 1'b0;
  endtask

  task automatic push_frames(input int q, input int n);
    @(posedge clk);
    frame_push <= 1'b1;
    push_queue <= 2'(q);
    repeat (n - 1) @(posedge clk);
    @(posedge clk);
    frame_push <= 1'b0;
  endtask

  task automatic wait_pulses(input int n);
    int waited;
    bit seen;
    for (int p = 0; p < n && !aborted; p++) begin
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < PULSE_TIMEOUT) begin
        @(posedge clk);
        seen = tsf_pulse_1m;
        waited++;
      end
      if (!seen) begin
        report_failure("no microsecond pulse arrived in time");
        aborted = 1'b1;
      end
    end
  endtask

  task automatic load_tsf(input logic [TW-1:0] value);
    @(posedge clk);
    tsf_load       <= 1'b1;
    tsf_load_value <= value;
    @(posedge clk);
    tsf_load       <= 1'b0;
    @(posedge clk);
    check_value("tsf_load", value, tsf_value);
  endtask

  task automatic expect_grant(input int q);
    int waited;
    waited = 0;
    while (grant_q.size() == 0 && waited < GRANT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (grant_q.size() == 0) begin
      report_failure($sformatf("no grant arrived for queue %0d", q));
      aborted = 1'b1;
    end else begin
      check_value("grant_order", q, grant_q.pop_front());
    end
  endtask

  task automatic send_done(input int max_delay, input int push_same);
    int delay;
    if (!tx_busy) begin
      report_failure("done requested while no transmission is in progress");
    end else begin
      delay = $unsigned($random(seed)) % (max_delay + 1);
      repeat (delay) begin
        @(posedge clk);
        check_value("busy_hold", 1, tx_busy);
        check_value("no_second_start", 0, tx_start);
      end
      @(posedge clk);
      tx_done <= 1'b1;
      if (push_same != 0) begin
        frame_push <= 1'b1;       // Same queue as the pop
        push_queue <= tx_queue;
      end
      @(posedge clk);
      tx_done    <= 1'b0;
      frame_push <= 1'b0;
    end
  endtask

  initial begin
    string         cmd;
    string         rest;
    int            fd;
    int            code;
    int            a;
    int            b;
    logic [TW-1:0] v;
    rstn = 1'b0;
    cfg_wr = 1'b0;
    cfg_op = tx_slice_pkg::CFG_TOTAL;
    cfg_idx = '0;
    cfg_value = '0;
    tsf_load = 1'b0;
    tsf_load_value = '0;
    frame_push = 1'b0;
    push_queue = '0;
    tx_done = 1'b0;
    n_mismatch = 0;
    n_fail = 0;
    cmd_no = 0;
    aborted = 1'b0;
    seed = 32'h493d;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_value("reset_slice_en", {NS{1'b1}}, slice_en);
    check_value("reset_tx_start", 0, tx_start);
    check_value("reset_tx_busy", 0, tx_busy);
    check_value("reset_queue_pending", 0, queue_pending);
    fd = $fopen("sim/tx_slice_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open sim/tx_slice_vectors.txt");
      aborted = 1'b1;
    end
    while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
      if (cmd.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);  // Skip comment line
      end else begin
        cmd_no++;
        case (cmd)
          "C": begin
            code = $fscanf(fd, "%d %d %h", a, b, v);
            if (code != 3) missing_arguments(cmd);
            else config_write(a, b, v[CW-1:0]);
          end
          "P": begin
            code = $fscanf(fd, "%d %d", a, b);
            if (code != 2) missing_arguments(cmd);
            else push_frames(a, b);
          end
          "W": begin
            code = $fscanf(fd, "%d", a);
            if (code != 1) missing_arguments(cmd);
            else wait_pulses(a);
          end
          "G": begin
            code = $fscanf(fd, "%d", a);
            if (code != 1) missing_arguments(cmd);
            else expect_grant(a);
          end
          "D": begin
            code = $fscanf(fd, "%d %d", a, b);
            if (code != 2) missing_arguments(cmd);
            else send_done(a, b);
          end
          "N": begin
            code = $fscanf(fd, "%d %d", a, b);
            if (code != 2) missing_arguments(cmd);
            for (int k = 0; k < b && !aborted; k++) begin
              expect_grant(a);
              if (!aborted) send_done(0, 0);
            end
          end
          "L": begin
            code = $fscanf(fd, "%h", v);
            if (code != 1) missing_arguments(cmd);
            else load_tsf(v);
          end
          "S": begin
            @(negedge clk);
            check_value("slice_window", m_en, slice_en);
            check_value("cycle_start0_spot", m_cnt[0] == m_total[0], cycle_start0);
          end
          default: begin
            report_failure($sformatf("unknown vector command %s", cmd));
            aborted = 1'b1;
          end
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    repeat (10) @(posedge clk);
    if (!aborted && grant_q.size() != 0) begin
      report_failure("a grant arrived that no vector expected");
    end
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
logic/tx_slice_pkg.sv
logic/tsf_timer.sv
logic/time_slice_gen.sv
logic/tx_queue_monitor.sv
logic/tx_slice_arbiter.sv
logic/tx_slice_top.sv
sim/tb_tx_slice_top.sv

// File: sim/tx_slice_vectors.txt
# C op idx value_hex (op 0 period, 1 start, 2 end) | P queue count | W pulses | G queue
# D max_delay push_same | N queue grants | L tsf_hex | S spot check of slice enables
W 2
L 00000000000a1000
W 2
P 1 1
P 2 1
P 3 1
G 1
D 2 0
G 2
D 5 0
G 3
D 0 0
C 0 1 9
C 1 1 2
C 2 1 5
C 0 2 4
C 1 2 3
C 2 2 1
W 4
S
P 2 1
W 12
S
P 1 1
G 1
D 0 0
C 1 2 0
G 2
D 0 0
P 3 1
G 3
P 0 1
D 20 1
G 0
D 30 0
G 3
D 0 0
P 3 260
N 3 255
S
W 2
